// ==== trace_pkg.sv ====
package trace_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scalar types.
    typedef logic [15:0] t_word;
    typedef logic [15:0] t_instr;
    typedef logic [3:0]  t_reg_idx;
    typedef logic [7:0]  t_simid;     // fetch order, from 0 after reset.
    typedef logic [15:0] t_stamp;     // cycle count.

    // instruction layout is {op, rd, rs1, rs2}, a nibble each.
    // li takes {rs1, rs2} as a zero-extended byte.
    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_XOR = 4'h3,
        OP_MUL = 4'h4,
        OP_LI  = 4'h5
    } t_opcode;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage packets.
    typedef struct packed {
        logic     valid;
        t_simid   simid;
        t_opcode  op;
        t_reg_idx rd;
        t_word    src1;
        t_word    src2;
    } t_uop;

    typedef struct packed {
        logic     valid;
        t_simid   simid;
        t_reg_idx rd;
        t_word    data;
    } t_wb_pkt;

    typedef struct packed {
        logic   valid;
        t_simid simid;
    } t_stage_evt;

    typedef struct packed {
        t_simid   simid;
        t_reg_idx rd;
        t_word    data;
        t_stamp   fetch_st;
        t_stamp   decode_st;
        t_stamp   issue_st;
        t_stamp   result_st;
        t_stamp   retire_st;
    } t_trace_rec;

    // multiplier walk, three cycles from issue to result.
    typedef enum logic [1:0] {
        EX_IDLE,
        EX_MUL1,
        EX_MUL2
    } t_ex_state;

endpackage

// ==== core_ctrl.sv ====
`timescale 1ns/10ps

module core_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  de_valid,
    input  trace_pkg::t_opcode    de_op,
    input  trace_pkg::t_reg_idx   de_rs1,
    input  trace_pkg::t_reg_idx   de_rs2,
    input  logic                  ex_valid,
    input  trace_pkg::t_reg_idx   ex_rd,
    input  trace_pkg::t_ex_state  ex_state,
    output logic                  fe_load,
    output logic                  de_load,
    output logic                  ex_issue,
    output logic                  stall
);

    logic mul_issued;   // a mul went into execute on the last edge.
    logic uses_srcs;
    logic raw_hit;
    logic mul_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_issued <= 1'b0;
        end else begin
            mul_issued <= ex_issue && (de_op == trace_pkg::OP_MUL);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // hazards.
    assign uses_srcs = (de_op != trace_pkg::OP_LI);   // li reads no register.

    // the execute stage writes back one cycle later, too late for a
    // same-cycle register read in decode.
    assign raw_hit = ex_valid && uses_srcs &&
                     ((de_rs1 == ex_rd) || (de_rs2 == ex_rd));

    // mul owns execute for its first two cycles.
    assign mul_busy = ((ex_state == trace_pkg::EX_IDLE) && mul_issued) ||
                      (ex_state == trace_pkg::EX_MUL1);

    // nothing to hold back with decode empty.
    assign stall = de_valid && (raw_hit || mul_busy);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage enables.
    assign fe_load  = !stall;
    assign de_load  = !stall;
    assign ex_issue = de_valid && !stall;   // bubble otherwise.

endmodule

// ==== decode_unit.sv ====
`timescale 1ns/10ps

module decode_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  trace_pkg::t_instr      instr,
    input  logic                   fe_load,
    input  logic                   de_load,
    output trace_pkg::t_reg_idx    rs1,
    output trace_pkg::t_reg_idx    rs2,
    input  trace_pkg::t_word       rd1,
    input  trace_pkg::t_word       rd2,
    output trace_pkg::t_opcode     de_op,
    output logic                   de_valid,
    output trace_pkg::t_uop        uop,
    output trace_pkg::t_stage_evt  fetch_evt,
    output trace_pkg::t_stage_evt  decode_evt
);

    trace_pkg::t_simid   next_simid;
    logic                fe_valid;
    trace_pkg::t_instr   fe_instr;
    trace_pkg::t_simid   fe_simid;
    trace_pkg::t_instr   de_instr;
    trace_pkg::t_simid   de_simid;
    trace_pkg::t_reg_idx de_rd;
    trace_pkg::t_word    imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_simid <= '0;
            fe_valid   <= 1'b0;
            de_valid   <= 1'b0;
        end else begin
            if (fe_load) begin
                fe_valid <= instr_valid;
                if (instr_valid) begin
                    next_simid <= next_simid + 1'b1;
                end
            end
            if (de_load) begin
                de_valid <= fe_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fe_load && instr_valid) begin
            fe_instr <= instr;
            fe_simid <= next_simid;
        end
        if (de_load) begin
            de_instr <= fe_instr;
            de_simid <= fe_simid;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field split and operand select.
    assign de_op = trace_pkg::t_opcode'(de_instr[15:12]);
    assign de_rd = de_instr[11:8];
    assign rs1   = de_instr[7:4];
    assign rs2   = de_instr[3:0];
    assign imm   = {8'h00, de_instr[7:0]};

    always_comb begin
        uop.valid = de_valid;
        uop.simid = de_simid;
        uop.op    = de_op;
        uop.rd    = de_rd;
        uop.src1  = (de_op == trace_pkg::OP_LI) ? imm : rd1;
        uop.src2  = (de_op == trace_pkg::OP_LI) ? '0 : rd2;
    end

    always_comb begin
        fetch_evt.valid  = fe_load && instr_valid;   // stamped at acceptance.
        fetch_evt.simid  = next_simid;
        decode_evt.valid = de_load && fe_valid;
        decode_evt.simid = fe_simid;
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  trace_pkg::t_reg_idx  rs1,
    input  trace_pkg::t_reg_idx  rs2,
    output trace_pkg::t_word     rd1,
    output trace_pkg::t_word     rd2,
    input  trace_pkg::t_wb_pkt   wb
);

    trace_pkg::t_word regs [16];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through, a read of the retiring rd sees the new value.
    assign rd1 = (wb.valid && (wb.rd == rs1)) ? wb.data : regs[rs1];
    assign rd2 = (wb.valid && (wb.rd == rs2)) ? wb.data : regs[rs2];

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ex_issue,
    input  trace_pkg::t_uop        uop,
    output logic                   ex_valid,
    output trace_pkg::t_reg_idx    ex_rd,
    output trace_pkg::t_ex_state   ex_state,
    output trace_pkg::t_wb_pkt     wb,
    output trace_pkg::t_stage_evt  issue_evt,
    output trace_pkg::t_stage_evt  result_evt,
    output trace_pkg::t_stage_evt  retire_evt
);

    trace_pkg::t_uop      ex_q;
    trace_pkg::t_ex_state state;
    trace_pkg::t_ex_state state_nxt;
    trace_pkg::t_word     alu_out;
    trace_pkg::t_word     prod_q;
    trace_pkg::t_simid    mul_simid;
    trace_pkg::t_reg_idx  mul_rd;
    trace_pkg::t_wb_pkt   res;
    trace_pkg::t_wb_pkt   ret_q;
    logic                 mul_start;

    assign mul_start = ex_q.valid && (ex_q.op == trace_pkg::OP_MUL);

    // execute register, a bubble when nothing issues.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_q.valid <= 1'b0;
        end else begin
            ex_q       <= uop;
            ex_q.valid <= ex_issue && uop.valid;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // multiplier.
    always_comb begin
        state_nxt = state;
        case (state)
            trace_pkg::EX_IDLE: begin
                if (mul_start) begin
                    state_nxt = trace_pkg::EX_MUL1;
                end
            end
            trace_pkg::EX_MUL1: state_nxt = trace_pkg::EX_MUL2;
            default:            state_nxt = trace_pkg::EX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= trace_pkg::EX_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            prod_q    <= ex_q.src1 * ex_q.src2;   // low half of the product.
            mul_simid <= ex_q.simid;
            mul_rd    <= ex_q.rd;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu and result select.
    always_comb begin
        case (ex_q.op)
            trace_pkg::OP_SUB: alu_out = ex_q.src1 - ex_q.src2;
            trace_pkg::OP_AND: alu_out = ex_q.src1 & ex_q.src2;
            trace_pkg::OP_XOR: alu_out = ex_q.src1 ^ ex_q.src2;
            trace_pkg::OP_LI:  alu_out = ex_q.src1;
            default:           alu_out = ex_q.src1 + ex_q.src2;
        endcase
    end

    always_comb begin
        res = '0;
        if (state == trace_pkg::EX_MUL2) begin
            res.valid = 1'b1;
            res.simid = mul_simid;
            res.rd    = mul_rd;
            res.data  = prod_q;
        end else if (ex_q.valid && !mul_start) begin
            res.valid = 1'b1;
            res.simid = ex_q.simid;
            res.rd    = ex_q.rd;
            res.data  = alu_out;
        end
    end

    // retire stage, drives the register write.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_q.valid <= 1'b0;
        end else begin
            ret_q <= res;
        end
    end

    assign ex_valid = ex_q.valid || (state != trace_pkg::EX_IDLE);
    assign ex_rd    = (state == trace_pkg::EX_IDLE) ? ex_q.rd : mul_rd;
    assign ex_state = state;
    assign wb       = ret_q;

    always_comb begin
        issue_evt.valid  = ex_issue && uop.valid;
        issue_evt.simid  = uop.simid;
        result_evt.valid = res.valid;
        result_evt.simid = res.simid;
        retire_evt.valid = ret_q.valid;
        retire_evt.simid = ret_q.simid;
    end

endmodule

// ==== lifecycle_tracker.sv ====
`timescale 1ns/10ps

module lifecycle_tracker #(
    parameter int TRACK_DEPTH = 8    // power of two, at least 2.
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  trace_pkg::t_stage_evt  fetch_evt,
    input  trace_pkg::t_stage_evt  decode_evt,
    input  trace_pkg::t_stage_evt  issue_evt,
    input  trace_pkg::t_stage_evt  result_evt,
    input  trace_pkg::t_stage_evt  retire_evt,
    input  trace_pkg::t_wb_pkt     wb,
    output logic                   rec_valid,
    output trace_pkg::t_trace_rec  rec,
    output logic                   track_err
);

    localparam int IDX_W = $clog2(TRACK_DEPTH);

    trace_pkg::t_stamp      cnt;
    logic [TRACK_DEPTH-1:0] fe_v;
    logic [TRACK_DEPTH-1:0] de_v;
    logic [TRACK_DEPTH-1:0] is_v;
    logic [TRACK_DEPTH-1:0] rs_v;
    trace_pkg::t_simid      ent_id [TRACK_DEPTH];
    trace_pkg::t_stamp      fe_st  [TRACK_DEPTH];
    trace_pkg::t_stamp      de_st  [TRACK_DEPTH];
    trace_pkg::t_stamp      is_st  [TRACK_DEPTH];
    trace_pkg::t_stamp      rs_st  [TRACK_DEPTH];
    logic [IDX_W-1:0]       fe_ix;
    logic [IDX_W-1:0]       de_ix;
    logic [IDX_W-1:0]       is_ix;
    logic [IDX_W-1:0]       rs_ix;
    logic [IDX_W-1:0]       rt_ix;
    logic                   err_now;

    // entry is live and belongs to this simid, not an alias.
    function automatic logic owns(input trace_pkg::t_stage_evt evt);
        logic [IDX_W-1:0] ix;
        ix = evt.simid[IDX_W-1:0];
        return fe_v[ix] && (ent_id[ix] == evt.simid);
    endfunction

    assign fe_ix = fetch_evt.simid[IDX_W-1:0];
    assign de_ix = decode_evt.simid[IDX_W-1:0];
    assign is_ix = issue_evt.simid[IDX_W-1:0];
    assign rs_ix = result_evt.simid[IDX_W-1:0];
    assign rt_ix = retire_evt.simid[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry state.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fe_v <= '0;
            de_v <= '0;
            is_v <= '0;
            rs_v <= '0;
        end else begin
            if (retire_evt.valid) begin   // free the entry.
                fe_v[rt_ix] <= 1'b0;
                de_v[rt_ix] <= 1'b0;
                is_v[rt_ix] <= 1'b0;
                rs_v[rt_ix] <= 1'b0;
            end
            if (decode_evt.valid) de_v[de_ix] <= 1'b1;
            if (issue_evt.valid)  is_v[is_ix] <= 1'b1;
            if (result_evt.valid) rs_v[rs_ix] <= 1'b1;
            if (fetch_evt.valid)  fe_v[fe_ix] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_evt.valid) begin
            fe_st[fe_ix]  <= cnt;
            ent_id[fe_ix] <= fetch_evt.simid;
        end
        if (decode_evt.valid) de_st[de_ix] <= cnt;
        if (issue_evt.valid)  is_st[is_ix] <= cnt;
        if (result_evt.valid) rs_st[rs_ix] <= cnt;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks and record.
    assign err_now =
        (fetch_evt.valid  && fe_v[fe_ix]) ||
        (decode_evt.valid && (!owns(decode_evt) || de_v[de_ix])) ||
        (issue_evt.valid  && (!owns(issue_evt)  || is_v[is_ix])) ||
        (result_evt.valid && (!owns(result_evt) || rs_v[rs_ix])) ||
        (retire_evt.valid && (!owns(retire_evt) || !wb.valid ||
                              (wb.simid != retire_evt.simid)));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            track_err <= 1'b0;
        end else if (err_now) begin
            track_err <= 1'b1;   // sticky.
        end
    end

    assign rec_valid = retire_evt.valid;

    always_comb begin
        rec.simid     = retire_evt.simid;
        rec.rd        = wb.rd;
        rec.data      = wb.data;
        rec.fetch_st  = fe_st[rt_ix];
        rec.decode_st = de_st[rt_ix];
        rec.issue_st  = is_st[rt_ix];
        rec.result_st = rs_st[rt_ix];
        rec.retire_st = cnt;
    end

endmodule

// ==== trace_core_top.sv ====
`timescale 1ns/10ps

module trace_core_top #(
    parameter int TRACK_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  trace_pkg::t_instr      instr,
    output logic                   stall,
    output logic                   rec_valid,
    output trace_pkg::t_trace_rec  rec,
    output logic                   track_err
);

    logic                  fe_load;
    logic                  de_load;
    logic                  ex_issue;
    logic                  de_valid;
    logic                  ex_valid;
    trace_pkg::t_opcode    de_op;
    trace_pkg::t_reg_idx   rs1;
    trace_pkg::t_reg_idx   rs2;
    trace_pkg::t_reg_idx   ex_rd;
    trace_pkg::t_word      rd1;
    trace_pkg::t_word      rd2;
    trace_pkg::t_uop       uop;
    trace_pkg::t_ex_state  ex_state;
    trace_pkg::t_wb_pkt    wb;
    trace_pkg::t_stage_evt fetch_evt;
    trace_pkg::t_stage_evt decode_evt;
    trace_pkg::t_stage_evt issue_evt;
    trace_pkg::t_stage_evt result_evt;
    trace_pkg::t_stage_evt retire_evt;

    core_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .de_valid (de_valid),
        .de_op    (de_op),
        .de_rs1   (rs1),
        .de_rs2   (rs2),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .ex_state (ex_state),
        .fe_load  (fe_load),
        .de_load  (de_load),
        .ex_issue (ex_issue),
        .stall    (stall)
    );

    decode_unit u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .fe_load     (fe_load),
        .de_load     (de_load),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd1         (rd1),
        .rd2         (rd2),
        .de_op       (de_op),
        .de_valid    (de_valid),
        .uop         (uop),
        .fetch_evt   (fetch_evt),
        .decode_evt  (decode_evt)
    );

    reg_file u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd1   (rd1),
        .rd2   (rd2),
        .wb    (wb)
    );

    exec_unit u_exec (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_issue   (ex_issue),
        .uop        (uop),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_state   (ex_state),
        .wb         (wb),
        .issue_evt  (issue_evt),
        .result_evt (result_evt),
        .retire_evt (retire_evt)
    );

    lifecycle_tracker #(
        .TRACK_DEPTH (TRACK_DEPTH)
    ) u_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_evt  (fetch_evt),
        .decode_evt (decode_evt),
        .issue_evt  (issue_evt),
        .result_evt (result_evt),
        .retire_evt (retire_evt),
        .wb         (wb),
        .rec_valid  (rec_valid),
        .rec        (rec),
        .track_err  (track_err)
    );

endmodule

// ==== trace_core_props.sv ====
`timescale 1ns/10ps

module trace_core_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  stall,
    input logic                  rec_valid,
    input trace_pkg::t_trace_rec rec,
    input trace_pkg::t_stage_evt result_evt
);

    // stamps never run backwards within one record.
    a_stamp_order: assert property (@(posedge clk) disable iff (!rst_n)
        rec_valid |-> (rec.fetch_st <= rec.decode_st) && (rec.decode_st <= rec.issue_st) &&
                      (rec.issue_st <= rec.result_st) && (rec.result_st <= rec.retire_st))
        else $error("trace record stamps run backwards");

    // the record leaves the cycle after the result, one count later.
    a_retire_next: assert property (@(posedge clk) disable iff (!rst_n)
        result_evt.valid |=> rec_valid && (rec.simid == $past(result_evt.simid)) &&
                             (rec.retire_st - rec.result_st == 16'd1))
        else $error("retire did not follow result by one cycle");

    // longest hold is a reader of a mul result, three cycles.
    a_stall_bound: assert property (@(posedge clk) disable iff (!rst_n)
        stall && $past(stall) && $past(stall, 2) |=> !stall)
        else $error("stall held for more than three cycles");

endmodule

bind trace_core_top trace_core_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .rec_valid  (rec_valid),
    .rec        (rec),
    .result_evt (result_evt)
);

// ==== tb_trace_core.sv ====
`timescale 1ns/10ps

module tb_trace_core;

    localparam int MAX_INSTR = 64;

    logic                  clk;
    logic                  rst_n;
    logic                  instr_valid;
    trace_pkg::t_instr     instr;
    logic                  stall;
    logic                  rec_valid;
    trace_pkg::t_trace_rec rec;
    logic                  track_err;

    // test data, indexed by sim id.
    logic [3:0]       op_a     [MAX_INSTR];
    logic [3:0]       rd_a     [MAX_INSTR];
    logic [3:0]       rs1_a    [MAX_INSTR];
    logic [3:0]       rs2_a    [MAX_INSTR];
    trace_pkg::t_word file_exp [MAX_INSTR];
    trace_pkg::t_word exp_data [MAX_INSTR];
    trace_pkg::t_word model    [16];

    int n_instr    = 0;
    int rec_count  = 0;
    int stall_seen = 0;
    int cycles     = 0;
    int limit      = 0;   // zero until the test length is known.
    int seed;

    trace_core_top #(
        .TRACK_DEPTH (8)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .stall       (stall),
        .rec_valid   (rec_valid),
        .rec         (rec),
        .track_err   (track_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers.
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            report_failure($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h",
                                     name, expected, actual));
        end
    endtask

    task automatic load_testdata();
        int    fd;
        int    code;
        string line;
        fd = $fopen("trace_testdata.txt", "r");
        assert (fd != 0) else report_failure("could not open trace_testdata.txt");
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() > 0 && line.getc(0) != "#") begin
                assert (n_instr < MAX_INSTR) else report_failure("too many lines in test data");
                code = $sscanf(line, "%h %h %h %h %h", op_a[n_instr], rd_a[n_instr],
                               rs1_a[n_instr], rs2_a[n_instr], file_exp[n_instr]);
                if (code == 5) n_instr++;   // blank lines fall through.
            end
        end
        $fclose(fd);
        assert (n_instr > 0) else report_failure("test data holds no instructions");
    endtask

    // in-order register model, 16-bit wrap throughout.
    task automatic build_expected();
        trace_pkg::t_word a;
        trace_pkg::t_word b;
        trace_pkg::t_word r;
        for (int k = 0; k < 16; k++) model[k] = '0;
        for (int i = 0; i < n_instr; i++) begin
            a = model[rs1_a[i]];
            b = model[rs2_a[i]];
            r = '0;
            case (op_a[i])
                trace_pkg::OP_ADD: r = a + b;
                trace_pkg::OP_SUB: r = a - b;
                trace_pkg::OP_AND: r = a & b;
                trace_pkg::OP_XOR: r = a ^ b;
                trace_pkg::OP_MUL: r = a * b;   // low half only.
                trace_pkg::OP_LI:  r = {8'h00, rs1_a[i], rs2_a[i]};
                default: report_failure($sformatf("unknown opcode %0h in test data entry %0d",
                                                  op_a[i], i));
            endcase
            model[rd_a[i]] = r;
            exp_data[i]    = r;
            check_value($sformatf("expected column of entry %0d", i),
                        int'(r), int'(file_exp[i]));
        end
    endtask

    // stall only depends on pipeline registers, so it is steady here.
    task automatic drive_instr(input int i);
        instr_valid = 1'b1;
        instr       = {op_a[i], rd_a[i], rs1_a[i], rs2_a[i]};
        while (stall) @(negedge clk);
        @(negedge clk);   // taken on the rising edge just passed.
        instr_valid = 1'b0;
    endtask

    task automatic check_record();
        int    sid;
        int    lat;
        string tag;
        sid = int'(rec.simid);
        tag = $sformatf("record %0d", rec_count);
        assert (rec_count < n_instr) else begin
            report_failure($sformatf("extra trace record for sim id %0d after the last one", sid));
        end
        check_value({tag, " simid"}, rec_count, sid);
        check_value({tag, " rd"}, int'(rd_a[sid]), int'(rec.rd));
        check_value({tag, " data"}, int'(exp_data[sid]), int'(rec.data));
        lat = (op_a[sid] == trace_pkg::OP_MUL) ? 3 : 1;
        check_value({tag, " issue to result"}, lat, int'(rec.result_st) - int'(rec.issue_st));
        check_value({tag, " result to retire"}, 1, int'(rec.retire_st) - int'(rec.result_st));
        assert ((rec.fetch_st < rec.decode_st) && (rec.decode_st < rec.issue_st)) else begin
            report_failure($sformatf("%s stamps out of order, fetch %0d decode %0d issue %0d",
                                     tag, rec.fetch_st, rec.decode_st, rec.issue_st));
        end
        rec_count++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor and timeout.
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!track_err) else report_failure("tracker raised its error flag");
            assert (!(stall && !DUT.de_valid)) else begin
                report_failure("stall went high with the decode stage empty");
            end
            if (stall) stall_seen++;
            if (rec_valid) check_record();
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            cycles++;
            assert (limit == 0 || cycles <= limit) else begin
                report_failure($sformatf("timeout after %0d cycles, %0d of %0d retired",
                                         cycles, rec_count, n_instr));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    initial begin
        int gap;
        seed        = 46;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        load_testdata();
        build_expected();
        limit = 20 * n_instr + 50;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_instr; i++) begin
            drive_instr(i);
            gap = {$random(seed)} % 3;   // 0 to 2 idle cycles.
            repeat (gap) @(negedge clk);
        end
        while (rec_count < n_instr) @(negedge clk);
        repeat (10) @(negedge clk);   // room for a stray duplicate.
        assert (stall_seen > 0) else report_failure("no stall seen during the run");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== trace_testdata.txt ====
# columns in hex: opcode rd rs1 rs2 expected_result
# opcodes 0 add, 1 sub, 2 and, 3 xor, 4 mul, 5 li (byte from rs1 and rs2 fields)
5 1 0 7 0007
5 2 1 3 0013
0 3 1 2 001a
4 4 3 3 02a4
0 5 4 1 02ab
1 6 1 5 fd5c
5 7 f f 00ff
2 8 6 7 005c
3 9 8 6 fd00
4 a 9 7 0300
4 b a 1 1500
0 c b b 2a00
5 d 8 0 0080
4 e d d 4000
4 e e 2 c000
1 f 0 e 4000
0 0 f d 4080
3 0 0 0 0000
5 3 a b 00ab
2 5 3 5 00ab
1 1 1 2 fff4
4 2 1 1 0090
0 4 2 4 0334
3 6 4 6 fe68

// ==== flist.f ====
trace_pkg.sv
core_ctrl.sv
decode_unit.sv
reg_file.sv
exec_unit.sv
lifecycle_tracker.sv
trace_core_top.sv
trace_core_props.sv
tb_trace_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_trace_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
